// ==== Makefile ====
# Verilator flow for the matrix float divider testbench

VERILATOR ?= verilator
TOP       ?= matrix_float_divider_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= -Wall
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
hdl/mfd_pkg.sv
hdl/float_div_if.sv
hdl/matrix_index_counter.sv
hdl/float_divider.sv
hdl/matrix_divide_sequencer.sv
hdl/matrix_float_divider.sv
tb/matrix_float_divider_tb.sv

// ==== hdl/float_div_if.sv ====
interface float_div_if;
  import mfd_pkg::*;

  // Launch pulse, operands held stable in its cycle
  logic               start;
  logic [float_w-1:0] dividend;
  logic [float_w-1:0] divisor;

  // One-cycle result strobe with its quotient
  logic               done;
  logic [float_w-1:0] quotient;

  // Sequencer side
  modport seq (
    output start,
    output dividend,
    output divisor,
    input  done,
    input  quotient
  );

  // Divider side
  modport div (
    input  start,
    input  dividend,
    input  divisor,
    output done,
    output quotient
  );

endinterface

// ==== hdl/float_divider.sv ====
module float_divider (
  input  logic     CLK,
  input  logic     RST,
  float_div_if.div div
);
  import mfd_pkg::*;

  // Control
  logic                              busy;
  logic [$clog2(div_cycles + 1)-1:0] iter;

  // Captured fields
  logic             sign;
  logic [exp_w-1:0] exp_q;
  logic             a_zero;
  logic             b_zero;

  // Mantissa datapath, hidden bits included
  logic [man_w+1:0] rem;
  logic [man_w:0]   dsr;
  logic [man_w+1:0] quo;
  logic [man_w+1:0] diff;
  logic             fits;

  logic accept;

  assign accept = div.start && !busy;

  // Trial subtraction of the restoring step
  assign fits = (rem >= {1'b0, dsr});
  assign diff = rem - {1'b0, dsr};

  ////////////////////
  // Control path

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      iter     <= '0;
      div.done <= 1'b0;
    end else begin
      div.done <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        iter <= '0;
      end else if (busy) begin
        if (iter == div_cycles) begin
          // Extra cycle for normalise and pack
          busy     <= 1'b0;
          div.done <= 1'b1;
        end else begin
          iter <= iter + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Datapath

  always_ff @(posedge CLK) begin
    if (accept) begin
      sign   <= div.dividend[float_w-1] ^ div.divisor[float_w-1];
      // Modulo arithmetic, range errors are out of scope
      exp_q  <= div.dividend[float_w-2 -: exp_w] - div.divisor[float_w-2 -: exp_w]
                + exp_w'(exp_bias);
      // Subnormals excluded, so a zero exponent means zero
      a_zero <= (div.dividend[float_w-2 -: exp_w] == '0);
      b_zero <= (div.divisor[float_w-2 -: exp_w] == '0);
      rem    <= {2'b01, div.dividend[man_w-1:0]};
      dsr    <= {1'b1, div.divisor[man_w-1:0]};
      quo    <= '0;
    end else if (busy && (iter != div_cycles)) begin
      // One quotient bit per cycle
      if (fits) begin
        rem <= {diff[man_w:0], 1'b0};
      end else begin
        rem <= {rem[man_w:0], 1'b0};
      end
      quo <= {quo[man_w:0], fits};
    end else if (busy) begin
      // Pack; 0/0 falls into the infinity case
      if (b_zero) begin
        div.quotient <= {sign, {exp_w{1'b1}}, {man_w{1'b0}}};
      end else if (a_zero) begin
        div.quotient <= {sign, {(float_w - 1){1'b0}}};
      end else if (quo[man_w+1]) begin
        // Quotient in [1,2), truncate the low bit
        div.quotient <= {sign, exp_q, quo[man_w:1]};
      end else begin
        // Quotient in [0.5,1), shift once and drop exponent
        div.quotient <= {sign, exp_q - 1'b1, quo[man_w-1:0]};
      end
    end
  end

  // Sequencer waits for done before a new launch
  a_no_start_busy : assert property (
    @(posedge CLK) disable iff (RST) div.start |-> !busy);

endmodule

// ==== hdl/matrix_divide_sequencer.sv ====
module matrix_divide_sequencer (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  logic                        a_in_i_enable,
  input  logic                        a_in_j_enable,
  input  logic                        b_in_i_enable,
  input  logic                        b_in_j_enable,
  input  logic [mfd_pkg::float_w-1:0] a_in,
  input  logic [mfd_pkg::float_w-1:0] b_in,
  input  logic                        row_end,
  input  logic                        matrix_end,
  input  logic [mfd_pkg::idx_w-1:0]   column,
  output logic                        clear,
  output logic                        advance,
  float_div_if.seq                    div,
  output logic                        ready,
  output logic                        out_i_enable,
  output logic                        out_j_enable,
  output logic [mfd_pkg::float_w-1:0] data_out
);
  import mfd_pkg::*;

  seq_state_t state;

  // Per-element operand bookkeeping
  logic               seen_a;
  logic               seen_b;
  logic [float_w-1:0] a_reg;
  logic [float_w-1:0] b_reg;

  logic first_col;
  logic take_a;
  logic take_b;
  logic got_a;
  logic got_b;

  ////////////////////
  // Strobe decode

  // Column 0 takes the i strobes, the rest take j
  assign first_col = (column == '0);
  assign take_a    = (state == st_load) && (first_col ? a_in_i_enable : a_in_j_enable);
  assign take_b    = (state == st_load) && (first_col ? b_in_i_enable : b_in_j_enable);

  // Seen earlier or arriving now
  assign got_a = seen_a || take_a;
  assign got_b = seen_b || take_b;

  // Counter steering
  assign clear   = (state == st_idle) && start;
  assign advance = (state == st_emit) && !matrix_end;

  assign div.dividend = a_reg;
  assign div.divisor  = b_reg;

  // Operand latches
  always_ff @(posedge CLK) begin
    if (take_a) a_reg <= a_in;
    if (take_b) b_reg <= b_in;
  end

  ////////////////////
  // Control FSM

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= st_idle;
      seen_a       <= 1'b0;
      seen_b       <= 1'b0;
      div.start    <= 1'b0;
      ready        <= 1'b0;
      out_i_enable <= 1'b0;
      out_j_enable <= 1'b0;
      data_out     <= '0;
    end else begin
      // Pulses by default
      div.start    <= 1'b0;
      ready        <= 1'b0;
      out_i_enable <= 1'b0;
      out_j_enable <= 1'b0;
      case (state)
        st_idle: begin
          if (start) state <= st_load;
        end
        st_load: begin
          if (got_a && got_b) begin
            // Both operands held, launch the divider
            div.start <= 1'b1;
            seen_a    <= 1'b0;
            seen_b    <= 1'b0;
            state     <= st_divide;
          end else begin
            seen_a <= got_a;
            seen_b <= got_b;
          end
        end
        st_divide: begin
          if (div.done) begin
            data_out     <= div.quotient;
            out_j_enable <= 1'b1;
            // Row strobe on every row end but the last
            out_i_enable <= row_end && !matrix_end;
            ready        <= matrix_end;
            state        <= st_emit;
          end
        end
        st_emit: begin
          // Counter steps here unless the matrix is finished
          state <= matrix_end ? st_idle : st_load;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Results only land while a division is pending
  a_done_in_divide : assert property (
    @(posedge CLK) disable iff (RST) div.done |-> state == st_divide);

  // Fixed divider latency
  a_div_latency : assert property (
    @(posedge CLK) disable iff (RST) div.start |-> ##(div_cycles + 2) div.done);

endmodule

// ==== hdl/matrix_float_divider.sv ====
module matrix_float_divider (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  logic [mfd_pkg::idx_w-1:0]   size_i_in,
  input  logic [mfd_pkg::idx_w-1:0]   size_j_in,
  input  logic                        a_in_i_enable,
  input  logic                        a_in_j_enable,
  input  logic                        b_in_i_enable,
  input  logic                        b_in_j_enable,
  input  logic [mfd_pkg::float_w-1:0] a_in,
  input  logic [mfd_pkg::float_w-1:0] b_in,
  output logic                        ready,
  output logic                        out_i_enable,
  output logic                        out_j_enable,
  output logic [mfd_pkg::float_w-1:0] data_out
);
  import mfd_pkg::*;

  // Counter handshake
  logic             clear;
  logic             advance;
  logic             row_end;
  logic             matrix_end;
  logic [idx_w-1:0] column;

  // Sequencer to divider link
  float_div_if div_bus ();

  ////////////////////
  // Instances

  matrix_divide_sequencer u_seq (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .a_in_i_enable(a_in_i_enable),
    .a_in_j_enable(a_in_j_enable),
    .b_in_i_enable(b_in_i_enable),
    .b_in_j_enable(b_in_j_enable),
    .a_in         (a_in),
    .b_in         (b_in),
    .row_end      (row_end),
    .matrix_end   (matrix_end),
    .column       (column),
    .clear        (clear),
    .advance      (advance),
    .div          (div_bus.seq),
    .ready        (ready),
    .out_i_enable (out_i_enable),
    .out_j_enable (out_j_enable),
    .data_out     (data_out)
  );

  // Row and column loops
  matrix_index_counter u_cnt (
    .CLK       (CLK),
    .RST       (RST),
    .clear     (clear),
    .advance   (advance),
    .size_i    (size_i_in),
    .size_j    (size_j_in),
    .column    (column),
    .row_end   (row_end),
    .matrix_end(matrix_end)
  );

  float_divider u_div (
    .CLK(CLK),
    .RST(RST),
    .div(div_bus.div)
  );

endmodule

// ==== hdl/matrix_index_counter.sv ====
module matrix_index_counter (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      clear,
  input  logic                      advance,
  input  logic [mfd_pkg::idx_w-1:0] size_i,
  input  logic [mfd_pkg::idx_w-1:0] size_j,
  output logic [mfd_pkg::idx_w-1:0] column,
  output logic                      row_end,
  output logic                      matrix_end
);
  import mfd_pkg::*;

  // Row index stays local
  logic [idx_w-1:0] row;

  // Last valid index of each loop
  logic [idx_w-1:0] col_last;
  logic [idx_w-1:0] row_last;

  assign col_last = size_j - 1'b1;
  assign row_last = size_i - 1'b1;

  assign row_end    = (column == col_last);
  assign matrix_end = row_end && (row == row_last);

  ////////////////////
  // Loop registers

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      column <= '0;
      row    <= '0;
    end else if (clear) begin
      column <= '0;
      row    <= '0;
    end else if (advance) begin
      // Wrap column at row end, step to next row
      if (row_end) begin
        column <= '0;
        row    <= row + 1'b1;
      end else begin
        column <= column + 1'b1;
      end
    end
  end

  // Sequencer stops stepping once the last element is out
  a_no_step_past_end : assert property (
    @(posedge CLK) disable iff (RST) !(advance && matrix_end && !clear));

endmodule

// ==== hdl/mfd_pkg.sv ====
package mfd_pkg;

  ////////////////////
  // Float format

  // Exponent and stored mantissa fields
  localparam int exp_w = 8;
  localparam int man_w = 23;

  // Sign, exponent and mantissa
  localparam int float_w = 1 + exp_w + man_w;

  // Bias of the exponent field
  localparam int exp_bias = 127;

  ////////////////////
  // Matrix loops

  // Sizes and indices, at most 255 rows or columns
  localparam int idx_w = 8;

  // 24 quotient bits plus one guard bit for normalising
  localparam int div_cycles = 25;

  ////////////////////
  // Sequencer FSM

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_divide,
    st_emit
  } seq_state_t;

endpackage

// ==== tb/matrix_div_stim.txt ====
# case <name>, then <size_i> <size_j>, then one line per element in row-major order
# <A hex> <B hex> <expected A/B hex, truncated toward zero>
case grid_3x4
3 4
41000000 40000000 40800000
3F800000 40800000 3E800000
40400000 40000000 3FC00000
C0A00000 40800000 BFA00000
3F400000 BF000000 BFC00000
3F800000 3FC00000 3F2AAAAA
40A00000 40400000 3FD55555
41200000 40400000 40555555
BF800000 41200000 BDCCCCCC
40E00000 3F800000 40E00000
80000000 C0000000 00000000
40000000 80000000 FF800000

case single_1x1
1 1
C0C00000 3FC00000 C0800000

case exact_2x2
2 2
40C00000 3FC00000 40800000
C0E00000 40000000 C0600000
41100000 C0800000 C0100000
3FC00000 3F400000 40000000

case trunc_1x5
1 5
3F800000 40400000 3EAAAAAA
40000000 40400000 3F2AAAAA
3F800000 41200000 3DCCCCCC
BF800000 C0400000 3EAAAAAA
3F800000 40E00000 3E124924

case zero_4x1
4 1
00000000 40000000 00000000
80000000 40000000 80000000
3F800000 00000000 7F800000
00000000 80000000 FF800000

// ==== tb/matrix_float_divider_tb.sv ====
module matrix_float_divider_tb;
  import mfd_pkg::*;

  // Bound on every wait loop
  localparam int timeout_cycles = 100;
  // Later operand strobe to out_j_enable
  localparam int result_latency = 29;

  logic               CLK;
  logic               RST;
  logic               start;
  logic [idx_w-1:0]   size_i_in;
  logic [idx_w-1:0]   size_j_in;
  logic               a_in_i_enable;
  logic               a_in_j_enable;
  logic               b_in_i_enable;
  logic               b_in_j_enable;
  logic [float_w-1:0] a_in;
  logic [float_w-1:0] b_in;
  logic               ready;
  logic               out_i_enable;
  logic               out_j_enable;
  logic [float_w-1:0] data_out;

  int    fd;
  string test_name;

  // Running totals of output pulses
  int j_count = 0;
  int i_count = 0;
  int r_count = 0;

  matrix_float_divider uut (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .size_i_in    (size_i_in),
    .size_j_in    (size_j_in),
    .a_in_i_enable(a_in_i_enable),
    .a_in_j_enable(a_in_j_enable),
    .b_in_i_enable(b_in_i_enable),
    .b_in_j_enable(b_in_j_enable),
    .a_in         (a_in),
    .b_in         (b_in),
    .ready        (ready),
    .out_i_enable (out_i_enable),
    .out_j_enable (out_j_enable),
    .data_out     (data_out)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Pulses seen at the edge after they rise
  always @(posedge CLK) begin
    if (!RST) begin
      if (out_j_enable) j_count = j_count + 1;
      if (out_i_enable) i_count = i_count + 1;
      if (ready) r_count = r_count + 1;
    end
  end

  ////////////////////
  // Helpers

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  // Skips comments and blank lines
  task automatic read_data_line(output string line, output bit found);
    int rc;
    bit eof;
    found = 1'b0;
    eof   = 1'b0;
    line  = "";
    while (!found && !eof) begin
      rc = $fgets(line, fd);
      if (rc == 0) eof = 1'b1;
      else if (line[0] != "#" && line[0] != "\n" && line[0] != "\r") found = 1'b1;
    end
  endtask

  // Column 0 uses the i strobes
  task automatic set_strobes(input bit first_col, input bit drive_a, input bit drive_b);
    a_in_i_enable = drive_a && first_col;
    a_in_j_enable = drive_a && !first_col;
    b_in_i_enable = drive_b && first_col;
    b_in_j_enable = drive_b && !first_col;
  endtask

  // Random order and spacing, operand buses scrambled after their strobe
  task automatic send_operands(input logic [31:0] a, input logic [31:0] b,
                               input bit first_col);
    int order;
    int gap_first;
    int gap_second;
    order      = $urandom % 3;
    gap_first  = $urandom % 6;
    gap_second = $urandom % 6;
    repeat (gap_first) @(negedge CLK);
    @(negedge CLK);
    if (order != 1) a_in = a;
    if (order != 0) b_in = b;
    set_strobes(first_col, order != 1, order != 0);
    @(negedge CLK);
    set_strobes(first_col, 1'b0, 1'b0);
    a_in = $urandom;
    b_in = $urandom;
    if (order != 2) begin
      repeat (gap_second) @(negedge CLK);
      // Second operand, the one not yet sent
      if (order == 1) a_in = a;
      else b_in = b;
      set_strobes(first_col, order == 1, order == 0);
      @(negedge CLK);
      set_strobes(first_col, 1'b0, 1'b0);
      a_in = $urandom;
      b_in = $urandom;
    end
  endtask

  task automatic wait_result(input logic [31:0] expected, input bit exp_row,
                             input bit exp_ready);
    int cycles;
    bit seen;
    // One cycle already gone since the last strobe
    cycles = 1;
    seen   = 1'b0;
    while (!seen && cycles < timeout_cycles) begin
      @(negedge CLK);
      cycles = cycles + 1;
      seen   = out_j_enable;
    end
    if (!seen) begin
      $display("Timeout: out_j_enable never arrived in test %s", test_name);
      abort_run();
    end
    check_value("quotient", expected, data_out);
    check_value("out_i_enable", 32'(exp_row), 32'(out_i_enable));
    check_value("ready", 32'(exp_ready), 32'(ready));
    check_value("latency", result_latency, cycles);
  endtask

  task automatic run_case(input int si, input int sj);
    int          base_j;
    int          base_i;
    int          base_r;
    int          r;
    int          c;
    int          rc;
    bit          found;
    bit          last_col;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] q;
    base_j = j_count;
    base_i = i_count;
    base_r = r_count;
    @(negedge CLK);
    size_i_in = idx_w'(si);
    size_j_in = idx_w'(sj);
    start     = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    for (r = 0; r < si; r++) begin
      for (c = 0; c < sj; c++) begin
        read_data_line(line, found);
        if (!found) begin
          $display("Stimulus file ended in the middle of test %s", test_name);
          abort_run();
        end
        rc = $sscanf(line, "%h %h %h", a, b, q);
        if (rc != 3) begin
          $display("Bad element line in test %s: %s", test_name, line);
          abort_run();
        end
        send_operands(a, b, c == 0);
        last_col = (c == sj - 1);
        wait_result(q, last_col && (r != si - 1), last_col && (r == si - 1));
      end
    end
    // Let the pulse counters catch up
    repeat (2) @(negedge CLK);
    check_value("element count", si * sj, j_count - base_j);
    check_value("row strobe count", si - 1, i_count - base_i);
    check_value("ready count", 1, r_count - base_r);
  endtask

  ////////////////////
  // Main sequence

  initial begin
    string line;
    bit    found;
    int    rc;
    int    si;
    int    sj;
    int    n_cases;
    RST       = 1'b1;
    start     = 1'b0;
    size_i_in = '0;
    size_j_in = '0;
    a_in      = '0;
    b_in      = '0;
    set_strobes(1'b0, 1'b0, 1'b0);
    n_cases   = 0;
    test_name = "reset";
    void'($urandom(32'hd9c3_f67d));
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Quiet outputs before the first start
    repeat (3) begin
      @(negedge CLK);
      check_value("ready", 0, 32'(ready));
      check_value("out_i_enable", 0, 32'(out_i_enable));
      check_value("out_j_enable", 0, 32'(out_j_enable));
      check_value("data_out", 0, data_out);
    end

    fd = $fopen("tb/matrix_div_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/matrix_div_stim.txt");
      abort_run();
    end
    found = 1'b1;
    while (found) begin
      read_data_line(line, found);
      if (found) begin
        rc = $sscanf(line, "case %s", test_name);
        if (rc != 1) begin
          $display("Expected a case line in the stimulus file, got: %s", line);
          abort_run();
        end
        read_data_line(line, found);
        rc = found ? $sscanf(line, "%d %d", si, sj) : 0;
        if (rc != 2) begin
          $display("Missing or bad size line for test %s", test_name);
          abort_run();
        end
        run_case(si, sj);
        n_cases = n_cases + 1;
      end
    end
    $fclose(fd);
    if (n_cases == 0) begin
      $display("No test cases found in the stimulus file");
      abort_run();
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule
